// File: Makefile
SIM := obj_dir/Vtb_alu_core

all: run

$(SIM): tb.f $(shell cat tb.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_core -f tb.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: alu_arith.sv
`timescale 1ns/10ps

module alu_arith (
    input  pic_alu_pkg::alu_op_e op,
    input  pic_alu_pkg::byte_t   w,
    input  pic_alu_pkg::byte_t   operand,
    output pic_alu_pkg::byte_t   sum,
    output logic                 carry,
    output logic                 digit_carry
);
    import pic_alu_pkg::*;

    byte_t               addend;
    logic                cin;
    logic [8:0]          full_sum;
    logic [NIBBLE_W:0]   low_sum;

    always_comb begin
        addend = w;
        cin    = 1'b0;
        case (op)
            OP_SUB: begin
                addend = ~w;       // operand - W as two's complement add
                cin    = 1'b1;
            end
            OP_INC: begin
                addend = '0;
                cin    = 1'b1;
            end
            OP_DEC: addend = '1;
            default: addend = w;   // ADD
        endcase
    end

    assign full_sum = {1'b0, operand} + {1'b0, addend} + 9'(cin);
    // Low nibble alone gives the carry out of bit 3
    assign low_sum = {1'b0, operand[NIBBLE_W-1:0]} + {1'b0, addend[NIBBLE_W-1:0]}
                   + (NIBBLE_W + 1)'(cin);

    assign sum         = full_sum[7:0];
    assign carry       = full_sum[8];        // No-borrow for subtract
    assign digit_carry = low_sum[NIBBLE_W];

endmodule

// File: alu_core.sv
`timescale 1ns/10ps

module alu_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  pic_alu_pkg::opcode_t in_opcode,
    input  pic_alu_pkg::byte_t   in_file,
    input  pic_alu_pkg::byte_t   in_literal,
    output logic                 res_valid,
    output pic_alu_pkg::byte_t   res_data,
    output logic                 res_to_f,
    output pic_alu_pkg::status_t res_status,
    input  logic                 credit_return
);

    logic                  accept;
    logic                  dec_valid;
    pic_alu_pkg::alu_op_e  dec_op;
    logic                  dec_to_f;
    pic_alu_pkg::bit_idx_t dec_bit;
    pic_alu_pkg::byte_t    dec_operand;

    assign accept = in_valid && in_ready;  // Slot already reserved at the gate

    alu_credit_gate u_credit_gate (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .credit_return (credit_return),
        .in_ready      (in_ready)
    );

    alu_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (accept),
        .in_opcode   (in_opcode),
        .in_file     (in_file),
        .in_literal  (in_literal),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_to_f    (dec_to_f),
        .dec_bit     (dec_bit),
        .dec_operand (dec_operand)
    );

    alu_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_to_f    (dec_to_f),
        .dec_bit     (dec_bit),
        .dec_operand (dec_operand),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_to_f    (res_to_f),
        .res_status  (res_status)
    );

endmodule

// File: alu_credit_gate.sv
`timescale 1ns/10ps

module alu_credit_gate (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic credit_return,
    output logic in_ready
);
    import alu_flow_pkg::*;

    credit_t credits;   // Free result slots
    logic    take;

    assign take     = in_valid && in_ready;
    assign in_ready = (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(CREDIT_MAX);
        end else if (take && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!take && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= credit_t'(CREDIT_MAX));
    a_no_extra_return: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> credits != credit_t'(CREDIT_MAX));

endmodule

// File: alu_decode.sv
`timescale 1ns/10ps

module alu_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,   // Acceptance strobe from the top
    input  pic_alu_pkg::opcode_t  in_opcode,
    input  pic_alu_pkg::byte_t    in_file,
    input  pic_alu_pkg::byte_t    in_literal,
    output logic                  dec_valid,
    output pic_alu_pkg::alu_op_e  dec_op,
    output logic                  dec_to_f,
    output pic_alu_pkg::bit_idx_t dec_bit,
    output pic_alu_pkg::byte_t    dec_operand
);
    import pic_alu_pkg::*;

    alu_op_e op_next;
    logic    to_f_next;
    logic    use_literal;
    opcode_t byte_key;

    assign byte_key = {in_opcode[6:1], 1'b0};  // Destination bit masked

    always_comb begin
        op_next     = OP_NOP;
        to_f_next   = 1'b0;
        use_literal = 1'b0;
        if (in_opcode == OPC_MOVWF) begin
            op_next   = OP_MOVWF;
            to_f_next = 1'b1;
        end else if (in_opcode == OPC_CLRW || in_opcode == OPC_CLRF) begin
            op_next   = OP_CLR;
            to_f_next = in_opcode[0];
        end else if (in_opcode[6:3] == OPC_BCF_BASE || in_opcode[6:3] == OPC_BSF_BASE) begin
            op_next   = (in_opcode[6:3] == OPC_BSF_BASE) ? OP_BSF : OP_BCF;
            to_f_next = 1'b1;                  // Bit ops always write the file
        end else if (in_opcode[6] && in_opcode[5]) begin
            use_literal = 1'b1;                // Literal ops only write W
            if (in_opcode[6:3] == OPC_MOVLW_PFX) op_next = OP_MOV;
            else if (in_opcode[6:1] == OPC_IORLW_PFX) op_next = OP_IOR;
            else if (in_opcode[6:1] == OPC_ANDLW_PFX) op_next = OP_AND;
            else if (in_opcode[6:1] == OPC_XORLW_PFX) op_next = OP_XOR;
            else if (in_opcode[6:2] == OPC_SUBLW_PFX) op_next = OP_SUB;
            else if (in_opcode[6:2] == OPC_ADDLW_PFX) op_next = OP_ADD;
        end else begin
            to_f_next = in_opcode[0];
            case (byte_key)
                OPC_SUBWF: op_next = OP_SUB;
                OPC_DECF:  op_next = OP_DEC;
                OPC_IORWF: op_next = OP_IOR;
                OPC_ANDWF: op_next = OP_AND;
                OPC_XORWF: op_next = OP_XOR;
                OPC_ADDWF: op_next = OP_ADD;
                OPC_MOVF:  op_next = OP_MOV;
                OPC_COMF:  op_next = OP_COM;
                OPC_INCF:  op_next = OP_INC;
                OPC_RRF:   op_next = OP_RRF;
                OPC_RLF:   op_next = OP_RLF;
                OPC_SWAPF: op_next = OP_SWAP;
                default:   to_f_next = 1'b0;   // NOP and undefined run on W
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_op      <= op_next;
            dec_to_f    <= to_f_next;
            dec_bit     <= in_opcode[2:0];
            dec_operand <= use_literal ? in_literal : in_file;
        end
    end

    a_op_known: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> !$isunknown(dec_op));

endmodule

// File: alu_execute.sv
`timescale 1ns/10ps

module alu_execute (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_valid,
    input  pic_alu_pkg::alu_op_e  dec_op,
    input  logic                  dec_to_f,
    input  pic_alu_pkg::bit_idx_t dec_bit,
    input  pic_alu_pkg::byte_t    dec_operand,
    output logic                  res_valid,
    output pic_alu_pkg::byte_t    res_data,
    output logic                  res_to_f,
    output pic_alu_pkg::status_t  res_status
);
    import pic_alu_pkg::*;

    byte_t   w_q;
    status_t status_q;
    status_t status_next;
    byte_t   arith_sum;
    logic    arith_c;
    logic    arith_dc;
    byte_t   logic_res;
    logic    logic_c;
    logic    is_arith;
    byte_t   result;

    alu_arith u_arith (
        .op          (dec_op),
        .w           (w_q),
        .operand     (dec_operand),
        .sum         (arith_sum),
        .carry       (arith_c),
        .digit_carry (arith_dc)
    );

    alu_logic u_logic (
        .op        (dec_op),
        .w         (w_q),
        .operand   (dec_operand),
        .bit_sel   (dec_bit),
        .carry_in  (status_q[STATUS_C]),
        .result    (logic_res),
        .carry_out (logic_c)
    );

    assign is_arith = (dec_op inside {OP_ADD, OP_SUB, OP_INC, OP_DEC});
    assign result   = is_arith ? arith_sum : logic_res;

    always_comb begin
        status_next = status_q;  // Flags hold unless the op owns them
        case (dec_op)
            OP_ADD, OP_SUB: begin
                status_next[STATUS_C]  = arith_c;
                status_next[STATUS_DC] = arith_dc;
                status_next[STATUS_Z]  = (result == '0);
            end
            OP_INC, OP_DEC, OP_AND, OP_IOR, OP_XOR, OP_COM, OP_MOV, OP_CLR:
                status_next[STATUS_Z] = (result == '0);
            OP_RLF, OP_RRF: status_next[STATUS_C] = logic_c;
            default: status_next = status_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            w_q       <= '0;
            status_q  <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= dec_valid;
            if (dec_valid) begin
                status_q <= status_next;
                if (!dec_to_f) begin
                    w_q <= result;  // W destination
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            res_data <= result;
            res_to_f <= dec_to_f;
        end
    end

    assign res_status = status_q;  // Already the post-instruction flags

    a_res_follows: assert property (@(posedge clk) disable iff (rst)
        dec_valid |=> res_valid);

endmodule

// File: alu_flow_pkg.sv
package alu_flow_pkg;

    // Result slots the consumer holds
    localparam int CREDIT_MAX = 4;

    // Must reach CREDIT_MAX itself, not just CREDIT_MAX-1
    typedef logic [$clog2(CREDIT_MAX + 1) - 1:0] credit_t;

endpackage

// File: alu_logic.sv
`timescale 1ns/10ps

module alu_logic (
    input  pic_alu_pkg::alu_op_e  op,
    input  pic_alu_pkg::byte_t    w,
    input  pic_alu_pkg::byte_t    operand,
    input  pic_alu_pkg::bit_idx_t bit_sel,
    input  logic                  carry_in,
    output pic_alu_pkg::byte_t    result,
    output logic                  carry_out
);
    import pic_alu_pkg::*;

    always_comb begin
        result    = operand;
        carry_out = carry_in;   // Only the rotates move C
        case (op)
            OP_AND:  result = w & operand;
            OP_IOR:  result = w | operand;
            OP_XOR:  result = w ^ operand;
            OP_COM:  result = ~operand;
            OP_MOV:  result = operand;
            OP_CLR:  result = '0;
            OP_SWAP: result = {operand[NIBBLE_W-1:0], operand[7:NIBBLE_W]};
            OP_RLF: begin
                result    = {operand[6:0], carry_in};
                carry_out = operand[7];
            end
            OP_RRF: begin
                result    = {carry_in, operand[7:1]};
                carry_out = operand[0];
            end
            OP_BCF:  result[bit_sel] = 1'b0;
            OP_BSF:  result[bit_sel] = 1'b1;
            // NOP and MOVWF report W, arith ops are taken from alu_arith
            default: result = w;
        endcase
    end

endmodule

// File: pic_alu_pkg.sv
package pic_alu_pkg;

    typedef logic [7:0] byte_t;     // W, file operand, literal, result
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] bit_idx_t;  // BCF/BSF bit position
    typedef logic [2:0] status_t;   // C, DC, Z

    localparam int STATUS_C  = 0;
    localparam int STATUS_DC = 1;
    localparam int STATUS_Z  = 2;

    localparam int NIBBLE_W = 4;  // DC boundary and SWAPF unit

    typedef enum logic [4:0] {
        OP_NOP,
        OP_MOVWF,
        OP_CLR,
        OP_SUB,
        OP_DEC,
        OP_IOR,
        OP_AND,
        OP_XOR,
        OP_ADD,
        OP_MOV,
        OP_COM,
        OP_INC,
        OP_RRF,
        OP_RLF,
        OP_SWAP,
        OP_BCF,
        OP_BSF
    } alu_op_e;

    // Fixed codes
    localparam opcode_t OPC_NOP   = 7'b0000000;
    localparam opcode_t OPC_MOVWF = 7'b0000001;
    localparam opcode_t OPC_CLRW  = 7'b0000010;
    localparam opcode_t OPC_CLRF  = 7'b0000011;

    // Byte ops, bit 0 selects the destination
    localparam opcode_t OPC_SUBWF = 7'b0000100;
    localparam opcode_t OPC_DECF  = 7'b0000110;
    localparam opcode_t OPC_IORWF = 7'b0001000;
    localparam opcode_t OPC_ANDWF = 7'b0001010;
    localparam opcode_t OPC_XORWF = 7'b0001100;
    localparam opcode_t OPC_ADDWF = 7'b0001110;
    localparam opcode_t OPC_MOVF  = 7'b0010000;
    localparam opcode_t OPC_COMF  = 7'b0010010;
    localparam opcode_t OPC_INCF  = 7'b0010100;
    localparam opcode_t OPC_RRF   = 7'b0011000;
    localparam opcode_t OPC_RLF   = 7'b0011010;
    localparam opcode_t OPC_SWAPF = 7'b0011100;

    // Bit ops, opcode[6:3], low three bits are the bit index
    localparam logic [3:0] OPC_BCF_BASE = 4'b0100;
    localparam logic [3:0] OPC_BSF_BASE = 4'b0101;

    // Literal ops, low bits are don't care
    localparam logic [3:0] OPC_MOVLW_PFX = 4'b1100;    // opcode[6:3]
    localparam logic [5:0] OPC_IORLW_PFX = 6'b111000;  // opcode[6:1]
    localparam logic [5:0] OPC_ANDLW_PFX = 6'b111001;
    localparam logic [5:0] OPC_XORLW_PFX = 6'b111010;
    localparam logic [4:0] OPC_SUBLW_PFX = 5'b11110;   // opcode[6:2]
    localparam logic [4:0] OPC_ADDLW_PFX = 5'b11111;

endpackage

// File: tb.f
pic_alu_pkg.sv
alu_flow_pkg.sv
alu_arith.sv
alu_logic.sv
alu_decode.sv
alu_execute.sv
alu_credit_gate.sv
alu_core.sv
tb_alu_core.sv

// File: tb_alu_core.sv
`timescale 1ns/10ps

module tb_alu_core;
    import pic_alu_pkg::*;
    import alu_flow_pkg::*;

    localparam int WAIT_LIMIT = 200;  // Cycles per wait loop
    localparam int RAND_OPS   = 300;

    typedef struct packed {
        byte_t   data;
        logic    to_f;
        status_t status;
        int      due;     // Cycle count when the beat must appear
    } exp_beat_t;

    logic    clk = 1'b0;
    logic    rst;
    logic    in_valid;
    logic    in_ready;
    opcode_t in_opcode;
    byte_t   in_file;
    byte_t   in_literal;
    logic    res_valid;
    byte_t   res_data;
    logic    res_to_f;
    status_t res_status;
    logic    credit_return = 1'b0;

    exp_beat_t   expq[$];
    byte_t       m_w;
    status_t     m_status;
    int          cycle = 0;
    int          free_credits;
    int          held;          // Beats received, credit not yet given back
    int          stalls = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic        withhold = 1'b0;
    logic [31:0] stim_lfsr = 32'h6b6d;
    logic [31:0] credit_lfsr = 32'h6b6d;

    // One of each op class, both destinations where there is a choice
    opcode_t dir_ops [38] = '{
        7'h00, 7'h60, 7'h0e, 7'h0f, 7'h04, 7'h05, 7'h7c, 7'h78, 7'h14, 7'h15,
        7'h06, 7'h07, 7'h0a, 7'h0b, 7'h08, 7'h09, 7'h0c, 7'h0d, 7'h12, 7'h13,
        7'h10, 7'h11, 7'h02, 7'h03, 7'h1c, 7'h1d, 7'h01, 7'h1a, 7'h1b, 7'h18,
        7'h19, 7'h23, 7'h2d, 7'h70, 7'h72, 7'h74, 7'h16, 7'h00
    };

    alu_core alu_core_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_opcode     (in_opcode),
        .in_file       (in_file),
        .in_literal    (in_literal),
        .res_valid     (res_valid),
        .res_data      (res_data),
        .res_to_f      (res_to_f),
        .res_status    (res_status),
        .credit_return (credit_return)
    );

    always #10 clk = ~clk;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
    endtask

    // Returns {C, DC, sum}
    function automatic logic [9:0] add_flags(input byte_t a, input byte_t b);
        logic [8:0] wide;
        wide = {1'b0, a} + {1'b0, b};
        return {wide[8], ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15, wide[7:0]};
    endfunction

    // Operand minus W, C and DC mean no borrow
    function automatic logic [9:0] sub_flags(input byte_t a, input byte_t w);
        return {a >= w, a[3:0] >= w[3:0], byte_t'(a - w)};
    endfunction

    task automatic model_accept(input opcode_t opc, input byte_t f, input byte_t lit);
        exp_beat_t beat;
        byte_t     res;
        logic      to_f;
        logic      upd_z;
        status_t   st;
        st    = m_status;
        res   = m_w;
        to_f  = opc[0];
        upd_z = 1'b1;
        casez (opc)
            7'b0000000: begin to_f = 1'b0; upd_z = 1'b0; end     // NOP
            7'b0000001: upd_z = 1'b0;                            // MOVWF keeps W
            7'b000001?: res = 8'h00;                             // CLRW, CLRF
            7'b000010?: {st[STATUS_C], st[STATUS_DC], res} = sub_flags(f, m_w);
            7'b000011?: res = f - 8'h01;
            7'b000100?: res = m_w | f;
            7'b000101?: res = m_w & f;
            7'b000110?: res = m_w ^ f;
            7'b000111?: {st[STATUS_C], st[STATUS_DC], res} = add_flags(f, m_w);
            7'b001000?: res = f;
            7'b001001?: res = ~f;
            7'b001010?: res = f + 8'h01;
            7'b001100?: begin
                res = {m_status[STATUS_C], f[7:1]};
                st[STATUS_C] = f[0];
                upd_z = 1'b0;
            end
            7'b001101?: begin
                res = {f[6:0], m_status[STATUS_C]};
                st[STATUS_C] = f[7];
                upd_z = 1'b0;
            end
            7'b001110?: begin res = {f[3:0], f[7:4]}; upd_z = 1'b0; end
            7'b0100???: begin res = f & ~(8'h01 << opc[2:0]); to_f = 1'b1; upd_z = 1'b0; end
            7'b0101???: begin res = f | (8'h01 << opc[2:0]); to_f = 1'b1; upd_z = 1'b0; end
            7'b1100???: begin res = lit; to_f = 1'b0; upd_z = 1'b0; end
            7'b111000?: begin res = m_w | lit; to_f = 1'b0; end
            7'b111001?: begin res = m_w & lit; to_f = 1'b0; end
            7'b111010?: begin res = m_w ^ lit; to_f = 1'b0; end
            7'b11110??: begin {st[STATUS_C], st[STATUS_DC], res} = sub_flags(lit, m_w); to_f = 1'b0; end
            7'b11111??: begin {st[STATUS_C], st[STATUS_DC], res} = add_flags(lit, m_w); to_f = 1'b0; end
            default: begin to_f = 1'b0; upd_z = 1'b0; end       // Undefined acts as NOP
        endcase
        if (upd_z) st[STATUS_Z] = (res == 8'h00);
        if (!to_f) m_w = res;
        m_status    = st;
        beat.data   = res;
        beat.to_f   = to_f;
        beat.status = st;
        beat.due    = cycle + 2;
        expq.push_back(beat);
    endtask

    task automatic check_beat();
        exp_beat_t head;
        if (res_valid) begin
            a_beat_expected: assert (expq.size() != 0) else begin
                errors++;
                $display("Result beat arrived with no instruction outstanding");
            end
            if (expq.size() != 0) begin
                head = expq.pop_front();
                a_beat_time: assert (head.due == cycle) else begin
                    errors++;
                    $display("Result beat at cycle %0d, expected at cycle %0d", cycle, head.due);
                end
                a_data: assert (res_data == head.data) else begin
                    errors++;
                    $display("Mismatch res_data: got %h expected %h", res_data, head.data);
                end
                a_to_f: assert (res_to_f == head.to_f) else begin
                    errors++;
                    $display("Mismatch res_to_f: got %h expected %h", res_to_f, head.to_f);
                end
                a_status: assert (res_status == head.status) else begin
                    errors++;
                    $display("Mismatch res_status: got %h expected %h", res_status, head.status);
                end
            end
        end else begin
            a_beat_on_time: assert (expq.size() == 0 || expq[0].due > cycle) else begin
                errors++;
                $display("Result beat missing at cycle %0d", cycle);
                void'(expq.pop_front());
            end
        end
    endtask

    // Samples at the edge, models acceptance and plays the consumer
    always @(posedge clk) begin : monitor
        logic give;
        cycle++;
        if (rst) begin
            free_credits = CREDIT_MAX;
            held = 0;
            credit_return <= 1'b0;
        end else begin
            a_ready: assert (in_ready == (free_credits != 0)) else begin
                errors++;
                $display("Mismatch in_ready: got %h expected %h", in_ready, free_credits != 0);
            end
            if (in_valid && !in_ready) stalls++;
            check_beat();
            if (in_valid && in_ready) begin
                model_accept(in_opcode, in_file, in_literal);
                free_credits--;
            end
            if (credit_return) begin
                free_credits++;
                held--;
            end
            if (res_valid) held++;
            give = credit_lfsr[0];
            credit_lfsr = lfsr_step(credit_lfsr);
            credit_return <= !withhold && held > 0 && give;
        end
    end

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d, beats outstanding: %0d",
                 errors, timeouts, expq.size());
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready && waited < WAIT_LIMIT);
        if (!in_ready) begin
            $display("Timeout: instruction not accepted within %0d cycles", WAIT_LIMIT);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic wait_stall();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (in_ready && waited < WAIT_LIMIT);
        if (in_ready) begin
            $display("Timeout: in_ready never dropped while credits were withheld");
            timeouts++;
            finish_run();
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((expq.size() != 0 || held != 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (expq.size() != 0 || held != 0) begin
            $display("Timeout: results or credits still outstanding at the end");
            timeouts++;
            finish_run();
        end
    endtask

    task automatic issue(input opcode_t opc, input byte_t f, input byte_t lit);
        in_valid   <= 1'b1;
        in_opcode  <= opc;
        in_file    <= f;
        in_literal <= lit;
        wait_accept();
        in_valid <= 1'b0;
    endtask

    initial begin
        logic [31:0] r_op;
        logic [31:0] r_f;
        logic [31:0] r_lit;
        logic [31:0] r_gap;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_opcode  = '0;
        in_file    = '0;
        in_literal = '0;
        m_w        = '0;
        m_status   = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        a_reset_state: assert (in_ready && !res_valid) else begin
            errors++;
            $display("After reset in_ready was low or res_valid was high");
        end

        foreach (dir_ops[i]) begin
            draw(8, r_f);
            draw(8, r_lit);
            issue(dir_ops[i], r_f[7:0], r_lit[7:0]);
        end

        for (int i = 0; i < RAND_OPS; i++) begin
            draw(7, r_op);
            draw(8, r_f);
            draw(8, r_lit);
            issue(r_op[6:0], r_f[7:0], r_lit[7:0]);
            draw(2, r_gap);
            if (r_gap == 0) @(posedge clk);   // Occasional idle cycle
        end

        // Back-pressure: hold MOVLW until every credit is gone
        withhold <= 1'b1;
        draw(8, r_lit);
        in_valid   <= 1'b1;
        in_opcode  <= 7'h60;
        in_literal <= r_lit[7:0];
        wait_stall();
        repeat (3) @(posedge clk);
        withhold <= 1'b0;
        wait_accept();
        in_valid <= 1'b0;

        wait_drain();
        a_stall_seen: assert (stalls > 0) else begin
            errors++;
            $display("Input back-pressure was never observed");
        end
        finish_run();
    end

endmodule
